// File: sources.f
src/tsn_frame_pkg.sv
src/tsn_buf_pkg.sv
src/pkt_buf_alloc.sv
src/descriptor_dispatch.sv
src/desc_queue.sv
src/tsn_ingress_top.sv
tb/tb_tsn_ingress.sv

// File: tb/tsn_ingress_golden.txt
# send tclass flow_len eth_type dbufid queue(T/D) exp_bufid lat_check, numbers in hex
# free id / held id cycles / ready queue hold|open|rand / drain queue / stall cycles
send 0 0000101 1800 01 T 00 1
send 2 0abc303 1800 03 T 01 1
send 3 0000404 1800 04 D 02 1
send 7 fffffff 1800 05 D 03 1
send 1 1234567 0800 06 D 04 1
drain T
drain D
free 01
free 00
send 1 0000909 1800 07 T 00 1
send 4 0000a0a 0800 08 D 01 1
send 0 0000b0b 1800 09 T 05 1
drain T
drain D
ready T hold
send 0 0001001 1800 10 T 06 0
send 6 0001002 86dd 11 D 07 1
send 1 0001003 1800 12 T 08 0
send 2 0001004 1800 13 T 09 0
send 0 0001005 1800 14 T 0a 0
send 1 0001006 1800 15 T 0b 0
stall 4
ready T rand
ready D rand
send 3 0002001 1800 00 D 0c 0
send 2 0002002 0806 01 D 0d 0
send 0 0002003 1800 02 T 0e 0
send 7 0002004 8100 03 D 0f 0
held 09 6
send 5 0003001 1800 04 D 09 0
drain T
drain D
ready T open
ready D open
free 03
send 2 0003003 1800 08 T 03 1
drain T

// File: tb/tb_tsn_ingress.sv
/* testbench for the ingress descriptor path with golden-file driver,
   output monitor, ready patterns and watchdog */

module tb_tsn_ingress;

    timeunit 1ns;
    timeprecision 1ps;

    import tsn_frame_pkg::*;
    import tsn_buf_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam     GOLDEN     = "tb/tsn_ingress_golden.txt";

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_desc_valid;
    logic                   o_desc_ready;
    in_desc_t               i_desc;
    eth_type_t              i_eth_type;
    logic [DBUFID_W-1:0]    i_dbufid;
    logic                   i_free_valid;
    logic [PKT_BUFID_W-1:0] i_free_bufid;
    logic                   o_tim_valid;
    logic                   i_tim_ready;
    tim_entry_t             o_tim_entry;
    logic                   o_doc_valid;
    logic                   i_doc_ready;
    doc_entry_t             o_doc_entry;

    // ready mode 0 holds low, 1 stays high and 2 is random
    int tim_mode = 1;
    int doc_mode = 1;

    // expected entries per queue with acceptance time and latency flag
    tim_entry_t tim_exp[$];
    time        tim_acc[$];
    bit         tim_lat[$];
    doc_entry_t doc_exp[$];
    time        doc_acc[$];
    bit         doc_lat[$];

    // pending id return for a send that waits on an empty pool
    logic [PKT_BUFID_W-1:0] held_id;
    int                     held_wait = 0;

    int errors  = 0;
    int checks  = 0;
    int n_lines = 0;

    tsn_ingress_top dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_tim_out();
        tim_entry_t exp;
        time        acc;
        bit         lat;
        if (tim_exp.size() == 0) begin
            errors++;
            $display("time-injection queue put out an entry that was never sent, at %0d ns",
                     $time);
        end else begin
            exp = tim_exp.pop_front();
            acc = tim_acc.pop_front();
            lat = tim_lat.pop_front();
            check_value("o_tim_entry.pkt_bufid", exp.desc.pkt_bufid, o_tim_entry.desc.pkt_bufid);
            check_value("o_tim_entry.desc", exp.desc.desc, o_tim_entry.desc.desc);
            check_value("o_tim_entry.dbufid", exp.dbufid, o_tim_entry.dbufid);
            if (lat) begin
                check_value("o_tim_valid latency", 2, ($time - acc) / CLK_PERIOD);
            end
        end
    endtask

    task automatic check_doc_out();
        doc_entry_t exp;
        time        acc;
        bit         lat;
        if (doc_exp.size() == 0) begin
            errors++;
            $display("ordinary queue put out an entry that was never sent, at %0d ns", $time);
        end else begin
            exp = doc_exp.pop_front();
            acc = doc_acc.pop_front();
            lat = doc_lat.pop_front();
            check_value("o_doc_entry.pkt_bufid", exp.desc.pkt_bufid, o_doc_entry.desc.pkt_bufid);
            check_value("o_doc_entry.desc", exp.desc.desc, o_doc_entry.desc.desc);
            if (lat) begin
                check_value("o_doc_valid latency", 2, ($time - acc) / CLK_PERIOD);
            end
        end
    endtask

    // outputs sampled at the rising edge before the registers move
    initial begin : monitor
        forever begin
            @(posedge i_clk);
            if (i_rst_n && o_tim_valid && i_tim_ready) begin
                check_tim_out();
            end
            if (i_rst_n && o_doc_valid && i_doc_ready) begin
                check_doc_out();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ready patterns and watchdog
    //////////////////////////////////////////////////////////////////////

    function automatic logic ready_level(input int mode);
        if (mode == 2) begin
            return ($urandom_range(0, 3) != 0);
        end
        return (mode == 1);
    endfunction

    // level picked at the rising edge and driven at the falling edge
    initial begin : ready_gen
        logic tim_next;
        logic doc_next;
        forever begin
            @(posedge i_clk);
            tim_next = ready_level(tim_mode);
            doc_next = ready_level(doc_mode);
            @(negedge i_clk);
            i_tim_ready = tim_next;
            i_doc_ready = doc_next;
        end
    end

    initial begin : watchdog
        wait (n_lines > 0);
        repeat (n_lines * 20) @(posedge i_clk);
        errors++;
        $display("run stopped on timeout after %0d cycles", n_lines * 20);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////////////////////////

    task automatic send_desc(input logic [2:0] tc, input logic [27:0] flow,
                             input logic [15:0] eth, input logic [DBUFID_W-1:0] dbuf,
                             input bit to_tim, input logic [PKT_BUFID_W-1:0] id,
                             input bit lat);
        tim_entry_t exp;
        doc_entry_t dexp;
        bit         accepted;
        int         waited;
        accepted             = 1'b0;
        waited               = 0;
        exp.desc.pkt_bufid   = id;
        exp.desc.desc.tclass = tc;
        exp.desc.desc.flow_len = flow;
        exp.dbufid           = dbuf;
        dexp.desc            = exp.desc;
        i_desc_valid    = 1'b1;
        i_desc.tclass   = tc;
        i_desc.flow_len = flow;
        i_eth_type      = eth;
        i_dbufid        = dbuf;
        while (!accepted) begin
            @(posedge i_clk);
            if (held_wait != 0) begin
                check_value("o_desc_ready", 0, o_desc_ready);
            end
            accepted = (o_desc_ready === 1'b1);
            if (accepted && to_tim) begin
                tim_exp.push_back(exp);
                tim_acc.push_back($time);
                tim_lat.push_back(lat);
            end else if (accepted) begin
                doc_exp.push_back(dexp);
                doc_acc.push_back($time);
                doc_lat.push_back(lat);
            end
            @(negedge i_clk);
            i_free_valid = 1'b0;
            if (!accepted && held_wait != 0) begin
                waited++;
                // consumer hands an id back while the send waits
                if (waited == held_wait) begin
                    i_free_valid = 1'b1;
                    i_free_bufid = held_id;
                    held_wait    = 0;
                end
            end
        end
        i_desc_valid = 1'b0;
    endtask

    task automatic return_id(input logic [PKT_BUFID_W-1:0] id);
        i_free_valid = 1'b1;
        i_free_bufid = id;
        @(negedge i_clk);
        i_free_valid = 1'b0;
    endtask

    task automatic run_golden(input int fd);
        logic [8*8-1:0]  cmd;
        logic [8*8-1:0]  arg;
        logic [8*8-1:0]  mode_s;
        logic [8*96-1:0] rest;
        logic [31:0]     v[0:5];
        int              code;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else if (cmd == "send") begin
                code = $fscanf(fd, "%h %h %h %h %s %h %h",
                               v[0], v[1], v[2], v[3], arg, v[4], v[5]);
                send_desc(v[0][2:0], v[1][27:0], v[2][15:0], v[3][DBUFID_W-1:0],
                          arg == "T", v[4][PKT_BUFID_W-1:0], v[5][0]);
            end else if (cmd == "free") begin
                code = $fscanf(fd, "%h", v[0]);
                return_id(v[0][PKT_BUFID_W-1:0]);
            end else if (cmd == "held") begin
                code      = $fscanf(fd, "%h %h", v[0], v[1]);
                held_id   = v[0][PKT_BUFID_W-1:0];
                held_wait = v[1];
            end else if (cmd == "ready") begin
                code = $fscanf(fd, "%s %s", arg, mode_s);
                v[0] = (mode_s == "hold") ? 0 : ((mode_s == "rand") ? 2 : 1);
                if (arg == "T") begin
                    tim_mode = v[0];
                end else begin
                    doc_mode = v[0];
                end
            end else if (cmd == "drain") begin
                code = $fscanf(fd, "%s", arg);
                while ((arg == "T") ? (tim_exp.size() != 0) : (doc_exp.size() != 0)) begin
                    @(negedge i_clk);
                end
            end else if (cmd == "stall") begin
                code = $fscanf(fd, "%h", v[0]);
                repeat (v[0]) begin
                    @(posedge i_clk);
                    check_value("o_desc_ready", 0, o_desc_ready);
                    @(negedge i_clk);
                end
            end else begin
                errors++;
                $display("golden file holds an unknown command %0s", cmd);
            end
            // idle gap between commands
            repeat ($urandom_range(0, 2)) @(negedge i_clk);
        end
    endtask

    initial begin : main
        int              fd;
        int              code;
        int              line_count;
        logic [8*96-1:0] line;
        void'($urandom(53838));
        i_rst_n      = 1'b0;
        i_desc_valid = 1'b0;
        i_desc       = '0;
        i_eth_type   = '0;
        i_dbufid     = '0;
        i_free_valid = 1'b0;
        i_free_bufid = '0;
        i_tim_ready  = 1'b1;
        i_doc_ready  = 1'b1;
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(posedge i_clk);
        check_value("o_desc_ready", 1, o_desc_ready);
        @(negedge i_clk);
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            errors++;
            $display("golden file %0s could not be opened", GOLDEN);
        end else begin
            // line count sets the watchdog limit
            line_count = 0;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    line_count++;
                end
            end
            n_lines = line_count;
            $fclose(fd);
            fd = $fopen(GOLDEN, "r");
            run_golden(fd);
            $fclose(fd);
        end
        repeat (4) @(negedge i_clk);
        if (tim_exp.size() + doc_exp.size() != 0) begin
            errors++;
            $display("%0d sent entries never left their queue", tim_exp.size() + doc_exp.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src/tsn_ingress_top.sv
/* ingress descriptor path: allocator, dispatch and the two class queues */

module tsn_ingress_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,

    // parser descriptor input
    input  logic                                i_desc_valid,
    output logic                                o_desc_ready,
    input  tsn_frame_pkg::in_desc_t             i_desc,
    input  tsn_frame_pkg::eth_type_t            i_eth_type,
    input  logic [tsn_buf_pkg::DBUFID_W-1:0]    i_dbufid,

    // packet-buffer id return
    input  logic                                i_free_valid,
    input  logic [tsn_buf_pkg::PKT_BUFID_W-1:0] i_free_bufid,

    // time-injection queue output
    output logic                                o_tim_valid,
    input  logic                                i_tim_ready,
    output tsn_buf_pkg::tim_entry_t             o_tim_entry,

    // ordinary-forwarding queue output
    output logic                                o_doc_valid,
    input  logic                                i_doc_ready,
    output tsn_buf_pkg::doc_entry_t             o_doc_entry
);

    import tsn_buf_pkg::*;

    logic                   alloc_valid;
    logic                   alloc_ready;
    logic [PKT_BUFID_W-1:0] alloc_bufid;

    logic                   tim_wr_valid;
    logic                   tim_wr_ready;
    tim_entry_t             tim_wr_entry;

    logic                   doc_wr_valid;
    logic                   doc_wr_ready;
    doc_entry_t             doc_wr_entry;

    pkt_buf_alloc alloc_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_alloc_valid  (alloc_valid),
        .o_alloc_bufid  (alloc_bufid),
        .i_alloc_ready  (alloc_ready),
        .i_free_valid   (i_free_valid),
        .i_free_bufid   (i_free_bufid)
    );

    descriptor_dispatch dispatch_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_desc_valid   (i_desc_valid),
        .i_desc         (i_desc),
        .i_eth_type     (i_eth_type),
        .i_dbufid       (i_dbufid),
        .o_desc_ready   (o_desc_ready),
        .i_alloc_valid  (alloc_valid),
        .i_alloc_bufid  (alloc_bufid),
        .o_alloc_ready  (alloc_ready),
        .o_tim_valid    (tim_wr_valid),
        .o_tim_entry    (tim_wr_entry),
        .i_tim_ready    (tim_wr_ready),
        .o_doc_valid    (doc_wr_valid),
        .o_doc_entry    (doc_wr_entry),
        .i_doc_ready    (doc_wr_ready)
    );

    // time-injection queue, entries keep the data-buffer id
    desc_queue #(.DEPTH(TIM_Q_DEPTH), .ENTRY_T(tim_entry_t)) tim_q_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (tim_wr_valid),
        .i_wr_entry (tim_wr_entry),
        .o_wr_ready (tim_wr_ready),
        .o_rd_valid (o_tim_valid),
        .o_rd_entry (o_tim_entry),
        .i_rd_ready (i_tim_ready)
    );

    desc_queue #(.DEPTH(DOC_Q_DEPTH), .ENTRY_T(doc_entry_t)) doc_q_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (doc_wr_valid),
        .i_wr_entry (doc_wr_entry),
        .o_wr_ready (doc_wr_ready),
        .o_rd_valid (o_doc_valid),
        .o_rd_entry (o_doc_entry),
        .i_rd_ready (i_doc_ready)
    );

endmodule

// File: src/desc_queue.sv
/* show-ahead synchronous FIFO for class queue entries,
   payload type set by parameter */

module desc_queue #(
    parameter int  DEPTH   = 4,
    parameter type ENTRY_T = logic [7:0]
) (
    input  logic   i_clk,
    input  logic   i_rst_n,

    // write side
    input  logic   i_wr_valid,
    input  ENTRY_T i_wr_entry,
    output logic   o_wr_ready,

    // read side, head entry shown while valid
    output logic   o_rd_valid,
    output ENTRY_T o_rd_entry,
    input  logic   i_rd_ready
);

    ENTRY_T                       mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;

    logic                         wr_en;
    logic                         rd_en;

    //////////////////////////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////////////////////////

    assign o_rd_valid = (count != 0);
    assign o_rd_entry = mem[rd_ptr];

    // a full queue still takes a write when the head leaves
    assign o_wr_ready = (count < DEPTH) || i_rd_ready;

    assign wr_en = i_wr_valid && o_wr_ready;
    assign rd_en = o_rd_valid && i_rd_ready;

    //////////////////////////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_entry;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // both at once leaves the count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_count_max: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        count <= DEPTH
    ) else $error("queue occupancy %0d above depth %0d", count, DEPTH);

endmodule

// File: src/descriptor_dispatch.sv
/* descriptor classifier that binds a packet-buffer id, builds the queued
   descriptor and steers it through a one-entry output register */

module descriptor_dispatch (
    input  logic                                i_clk,
    input  logic                                i_rst_n,

    // parser side
    input  logic                                i_desc_valid,
    input  tsn_frame_pkg::in_desc_t             i_desc,
    input  tsn_frame_pkg::eth_type_t            i_eth_type,
    input  logic [tsn_buf_pkg::DBUFID_W-1:0]    i_dbufid,
    output logic                                o_desc_ready,

    // allocator side
    input  logic                                i_alloc_valid,
    input  logic [tsn_buf_pkg::PKT_BUFID_W-1:0] i_alloc_bufid,
    output logic                                o_alloc_ready,

    // time-injection queue write
    output logic                                o_tim_valid,
    output tsn_buf_pkg::tim_entry_t             o_tim_entry,
    input  logic                                i_tim_ready,

    // ordinary-forwarding queue write
    output logic                                o_doc_valid,
    output tsn_buf_pkg::doc_entry_t             o_doc_entry,
    input  logic                                i_doc_ready
);

    import tsn_frame_pkg::*;
    import tsn_buf_pkg::*;

    logic                out_valid;
    logic                out_is_tim;
    out_desc_t           out_desc;
    logic [DBUFID_W-1:0] out_dbufid;

    logic                is_tim;
    logic                drain;
    logic                reg_free;
    logic                accept;

    //////////////////////////////////////////////////////////////////////
    // classification and handshakes
    //////////////////////////////////////////////////////////////////////

    // TSN EtherType with a low traffic class
    assign is_tim = (i_eth_type == TSN_ETH_TYPE) && (i_desc.tclass <= TS_CLASS_MAX);

    assign drain    = (o_tim_valid && i_tim_ready) || (o_doc_valid && i_doc_ready);
    assign reg_free = !out_valid || drain;

    // descriptor and id are taken at the same edge
    assign o_desc_ready  = i_alloc_valid && reg_free;
    assign o_alloc_ready = i_desc_valid && reg_free;
    assign accept        = i_desc_valid && i_alloc_valid && reg_free;

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            out_valid  <= 1'b0;
            out_is_tim <= 1'b0;
        end else if (accept) begin
            out_valid  <= 1'b1;
            out_is_tim <= is_tim;
        end else if (drain) begin
            out_valid  <= 1'b0;
        end
    end

    // payload with the id in the top bits
    always_ff @(posedge i_clk) begin
        if (accept) begin
            out_desc.pkt_bufid <= i_alloc_bufid;
            out_desc.desc      <= i_desc;
            out_dbufid         <= i_dbufid;
        end
    end

    assign o_tim_valid = out_valid && out_is_tim;
    assign o_doc_valid = out_valid && !out_is_tim;

    always_comb begin
        o_tim_entry.desc   = out_desc;
        o_tim_entry.dbufid = out_dbufid;
        o_doc_entry.desc   = out_desc;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // the parser keeps a waiting descriptor until it is taken
    a_desc_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_desc_valid && !o_desc_ready |=>
            i_desc_valid && $stable({i_desc, i_eth_type, i_dbufid})
    ) else $error("descriptor dropped or changed before it was taken");

    // a stalled entry waits unchanged for its queue
    a_tim_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_tim_valid && !i_tim_ready |=> o_tim_valid && $stable(o_tim_entry)
    ) else $error("time-injection entry changed while stalled");

    a_doc_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_doc_valid && !i_doc_ready |=> o_doc_valid && $stable(o_doc_entry)
    ) else $error("ordinary entry changed while stalled");

endmodule

// File: src/pkt_buf_alloc.sv
/* packet-buffer id allocator: free bitmap, lowest-free priority
   encoder, release port */

module pkt_buf_alloc (
    input  logic                                i_clk,
    input  logic                                i_rst_n,

    // id offer to dispatch
    output logic                                o_alloc_valid,
    output logic [tsn_buf_pkg::PKT_BUFID_W-1:0] o_alloc_bufid,
    input  logic                                i_alloc_ready,

    // id return from the consumers
    input  logic                                i_free_valid,
    input  logic [tsn_buf_pkg::PKT_BUFID_W-1:0] i_free_bufid
);

    import tsn_buf_pkg::*;

    // one bit per id, set while the id is free
    logic [BUF_NUM-1:0] free_map;
    logic [BUF_NUM-1:0] take_mask;
    logic [BUF_NUM-1:0] give_mask;

    //////////////////////////////////////////////////////////////////////
    // lowest free id
    //////////////////////////////////////////////////////////////////////

    assign o_alloc_valid = |free_map;

    // scan downwards so the lowest set bit wins
    always_comb begin
        o_alloc_bufid = '0;
        for (int i = BUF_NUM - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                o_alloc_bufid = PKT_BUFID_W'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bitmap update
    //////////////////////////////////////////////////////////////////////

    assign take_mask = (o_alloc_valid && i_alloc_ready) ?
                       (BUF_NUM'(1) << o_alloc_bufid) : '0;
    assign give_mask = i_free_valid ? (BUF_NUM'(1) << i_free_bufid) : '0;

    // a return and a hand-out of different ids can share an edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            free_map <= '1;
        end else begin
            free_map <= (free_map & ~take_mask) | give_mask;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // consumers only return ids that were handed out
    a_free_not_free: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_free_valid |-> ((free_map & give_mask) == '0)
    ) else $error("returned packet-buffer id %0d is already free", i_free_bufid);

    a_free_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_free_valid |-> (i_free_bufid < BUF_NUM)
    ) else $error("returned packet-buffer id %0d out of pool", i_free_bufid);

endmodule

// File: src/tsn_buf_pkg.sv
/* buffer pool sizes, queue depths and class queue entry types */

package tsn_buf_pkg;

    //////////////////////////////////////////////////////////////////////
    // pool and queue sizes
    //////////////////////////////////////////////////////////////////////

    // id width follows the descriptor field
    localparam int PKT_BUFID_W = $bits(tsn_frame_pkg::desc_bufid_t);
    localparam int DBUFID_W    = 5;

    // ids 0..BUF_NUM-1 only
    localparam int BUF_NUM     = 16;

    localparam int TIM_Q_DEPTH = 4;
    localparam int DOC_Q_DEPTH = 4;

    //////////////////////////////////////////////////////////////////////
    // queue entries
    //////////////////////////////////////////////////////////////////////

    // time-injection entry keeps the data-buffer id, 45 bits
    typedef struct packed {
        tsn_frame_pkg::out_desc_t desc;
        logic [DBUFID_W-1:0]      dbufid;
    } tim_entry_t;

    // ordinary-forwarding entry, 40 bits
    typedef struct packed {
        tsn_frame_pkg::out_desc_t desc;
    } doc_entry_t;

endpackage

// File: src/tsn_frame_pkg.sv
/* frame-side definitions: EtherType and traffic class constants,
   parser descriptor and queued descriptor layouts */

package tsn_frame_pkg;

    //////////////////////////////////////////////////////////////////////
    // frame constants
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] eth_type_t;

    // EtherType that marks a time-sensitive frame
    localparam eth_type_t TSN_ETH_TYPE = 16'h1800;

    // classes 0..TS_CLASS_MAX go to the time-injection queue
    localparam logic [2:0] TS_CLASS_MAX = 3'd2;

    //////////////////////////////////////////////////////////////////////
    // descriptor layouts
    //////////////////////////////////////////////////////////////////////

    // parser descriptor, 31 bits
    typedef struct packed {
        logic [2:0]  tclass;    // bits 30..28
        logic [27:0] flow_len;  // flow id and frame length
    } in_desc_t;

    // packet-buffer id field of the queued descriptor
    typedef logic [8:0] desc_bufid_t;

    // queued descriptor, 40 bits, id on top
    typedef struct packed {
        desc_bufid_t pkt_bufid;
        in_desc_t    desc;
    } out_desc_t;

endpackage
